//--- conv_engine.f
+incdir+include
hdl/conv_pkg.sv
hdl/multiplier.sv
hdl/n_delay.sv
hdl/accumulator.sv
hdl/conv_skid_buffer.sv
hdl/conv_engine.sv
hdl/conv_top.sv
tests/conv_tb_asserts.sv
tests/conv_tb.sv

//--- hdl/accumulator.sv
// Signed accumulator with load
`timescale 1ns/1ps
`default_nettype none

module accumulator (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 ce,
  input  wire                 bypass,
  input  wire conv_pkg::acc_t b,
  output conv_pkg::acc_t      q
);

  conv_pkg::acc_t sum;

  // Wraps at the accumulator width
  assign sum = q + b;

  always_ff @(posedge clk) begin
    if (rst) begin
      q <= '0;
    end else if (ce) begin
      if (bypass) begin
        q <= b;    // Start of a new sum
      end else begin
        q <= sum;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/conv_engine.sv
// Convolution multiply-accumulate engine
`timescale 1ns/1ps
`default_nettype none
`include "conv_consts.svh"

module conv_engine (
  input  wire                                                     clk,
  input  wire                                                     rst,
  input  wire                                                     s_valid,
  input  wire                                                     s_last,
  input  wire conv_pkg::user_t                                    s_user,
  input  wire conv_pkg::pixel_t  [`CONV_UNITS-1:0]                s_pixels,
  input  wire conv_pkg::weight_t [`CONV_MEMBERS-1:0]              s_weights,
  output logic                                                    s_ready,
  output logic                                                    m_valid,
  output logic                                                    m_last,
  output conv_pkg::acc_t [`CONV_MEMBERS-1:0][`CONV_UNITS-1:0]     m_data
);

  localparam int UNITS   = `CONV_UNITS;
  localparam int MEMBERS = `CONV_MEMBERS;
  localparam int LATENCY = `CONV_LATENCY_MULTIPLIER;
  localparam int KW2_MAX = `CONV_KW_MAX / 2;

  logic               ce_mul;
  logic               stall_sel;
  logic               stall_next;
  logic               mul_valid;
  logic               mul_last;
  logic               mul_fire;
  logic               mul_cin_last;
  conv_pkg::user_t    mul_user;
  conv_pkg::kw2_t     mul_kw2;
  conv_pkg::kw2_t     kw2_sel;
  logic               sum_done;
  logic               bypass;
  logic               ce_acc        [MEMBERS];
  logic               sum_start_lut [KW2_MAX+1][MEMBERS];
  conv_pkg::product_t mul_p         [MEMBERS][UNITS];
  conv_pkg::acc_t     acc_in        [MEMBERS][UNITS];
  conv_pkg::acc_t     acc_q         [MEMBERS][UNITS];

  // Multipliers freeze during the neighbor-add cycle
  assign ce_mul  = !stall_sel;
  assign s_ready = ce_mul;

  n_delay #(
    .N     (LATENCY),
    .WIDTH (`CONV_USER_WIDTH + 2)
  ) mul_ctrl (
    .clk      (clk),
    .rst      (rst),
    .ce       (ce_mul),
    .data_in  ({s_valid, s_last, s_user}),
    .data_out ({mul_valid, mul_last, mul_user})
  );

  assign mul_kw2      = mul_user[`CONV_I_KW2 +: `CONV_BITS_KW2];
  assign mul_cin_last = mul_user[`CONV_I_IS_CIN_LAST];
  assign mul_fire     = mul_valid && !stall_sel;
  assign stall_next   = mul_fire && mul_cin_last && (mul_kw2 != '0);

  // New sum on a first column or after a finished sum
  assign bypass = !stall_sel && (sum_done || mul_user[`CONV_I_IS_W_FIRST]);

  always_ff @(posedge clk) begin
    if (rst) begin
      stall_sel <= 1'b0;
      kw2_sel   <= '0;
      sum_done  <= 1'b1;
      m_valid   <= 1'b0;
      m_last    <= 1'b0;
    end else begin
      stall_sel <= stall_next;
      m_valid   <= stall_sel || (mul_fire && mul_cin_last && (mul_kw2 == '0));
      if (stall_next) kw2_sel <= mul_kw2;  // Kernel of the sum being shifted
      if (mul_fire) begin
        sum_done <= mul_cin_last;
        if (mul_cin_last) m_last <= mul_last;
      end
    end
  end

  for (genvar m = 0; m < MEMBERS; m++) begin : g_member
    // Members that open a kernel window keep their own sum
    for (genvar k2 = 0; k2 <= KW2_MAX; k2++) begin : g_kw2
      assign sum_start_lut[k2][m] = (m % (2 * k2 + 1)) == 0;
    end

    assign ce_acc[m] = stall_sel ? !sum_start_lut[kw2_sel][m] : mul_valid;

    for (genvar u = 0; u < UNITS; u++) begin : g_unit
      multiplier #(
        .LATENCY (LATENCY)
      ) mul (
        .clk (clk),
        .ce  (ce_mul),
        .a   (s_pixels[u]),
        .b   (s_weights[m]),
        .p   (mul_p[m][u])
      );

      if (m == 0) begin : g_edge
        assign acc_in[m][u] = stall_sel ? '0 : conv_pkg::acc_t'(mul_p[m][u]);
      end else begin : g_inner
        assign acc_in[m][u] = stall_sel ? acc_q[m-1][u]  // Left neighbor, pre-shift
                                        : conv_pkg::acc_t'(mul_p[m][u]);
      end

      accumulator acc (
        .clk    (clk),
        .rst    (rst),
        .ce     (ce_acc[m]),
        .bypass (bypass),
        .b      (acc_in[m][u]),
        .q      (acc_q[m][u])
      );
    end
  end

  always_comb begin
    for (int m = 0; m < MEMBERS; m++) begin
      for (int u = 0; u < UNITS; u++) begin
        m_data[m][u] = acc_q[m][u];
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/conv_pkg.sv
// Convolution engine types
`default_nettype none
`include "conv_consts.svh"

package conv_pkg;

  // Input operands
  typedef logic signed [`CONV_WORD_WIDTH-1:0] pixel_t;
  typedef logic signed [`CONV_WORD_WIDTH-1:0] weight_t;

  // Full-precision product of one pixel and one weight
  typedef logic signed [2*`CONV_WORD_WIDTH-1:0] product_t;

  // Running sum, wraps on overflow
  typedef logic signed [`CONV_WORD_WIDTH_ACC-1:0] acc_t;

  // Half kernel width, k = 2*kw2 + 1
  typedef logic [`CONV_BITS_KW2-1:0] kw2_t;

  // Side-band flags and kw2
  typedef logic [`CONV_USER_WIDTH-1:0] user_t;

endpackage

`default_nettype wire

//--- hdl/conv_skid_buffer.sv
// Input skid buffer
`timescale 1ns/1ps
`default_nettype none
`include "conv_consts.svh"

module conv_skid_buffer (
  input  wire                                        clk,
  input  wire                                        rst,
  input  wire                                        s_valid,
  input  wire                                        s_last,
  input  wire conv_pkg::user_t                       s_user,
  input  wire conv_pkg::pixel_t  [`CONV_UNITS-1:0]   s_pixels,
  input  wire conv_pkg::weight_t [`CONV_MEMBERS-1:0] s_weights,
  output logic                                       s_ready,
  output logic                                       m_valid,
  output logic                                       m_last,
  output conv_pkg::user_t                            m_user,
  output conv_pkg::pixel_t  [`CONV_UNITS-1:0]        m_pixels,
  output conv_pkg::weight_t [`CONV_MEMBERS-1:0]      m_weights,
  input  wire                                        m_ready
);

  logic                                  skid_last;
  conv_pkg::user_t                       skid_user;
  conv_pkg::pixel_t  [`CONV_UNITS-1:0]   skid_pixels;
  conv_pkg::weight_t [`CONV_MEMBERS-1:0] skid_weights;

  // s_ready low means the skid entry is occupied
  always_ff @(posedge clk) begin
    if (rst) begin
      s_ready <= 1'b1;
    end else if (!s_ready) begin
      if (m_ready) s_ready <= 1'b1;  // Entry drains downstream
    end else if (s_valid && !m_ready) begin
      s_ready <= 1'b0;               // Beat caught during a stall
    end
  end

  always_ff @(posedge clk) begin
    if (s_ready) begin
      skid_last    <= s_last;
      skid_user    <= s_user;
      skid_pixels  <= s_pixels;
      skid_weights <= s_weights;
    end
  end

  // Pass through when empty
  assign m_valid   = !s_ready || s_valid;
  assign m_last    = s_ready ? s_last    : skid_last;
  assign m_user    = s_ready ? s_user    : skid_user;
  assign m_pixels  = s_ready ? s_pixels  : skid_pixels;
  assign m_weights = s_ready ? s_weights : skid_weights;

endmodule

`default_nettype wire

//--- hdl/conv_top.sv
// Convolution engine top level
`timescale 1ns/1ps
`default_nettype none
`include "conv_consts.svh"

module conv_top (
  input  wire                                                 clk,
  input  wire                                                 rst,
  input  wire                                                 s_valid,
  input  wire                                                 s_last,
  input  wire conv_pkg::user_t                                s_user,
  input  wire conv_pkg::pixel_t  [`CONV_UNITS-1:0]            s_pixels,
  input  wire conv_pkg::weight_t [`CONV_MEMBERS-1:0]          s_weights,
  output logic                                                s_ready,
  output logic                                                m_valid,
  output logic                                                m_last,
  output conv_pkg::acc_t [`CONV_MEMBERS-1:0][`CONV_UNITS-1:0] m_data
);

  // Skid buffer to engine
  logic                                  e_valid;
  logic                                  e_last;
  conv_pkg::user_t                       e_user;
  conv_pkg::pixel_t  [`CONV_UNITS-1:0]   e_pixels;
  conv_pkg::weight_t [`CONV_MEMBERS-1:0] e_weights;
  logic                                  e_ready;

  conv_skid_buffer skid (
    .clk       (clk),
    .rst       (rst),
    .s_valid   (s_valid),
    .s_last    (s_last),
    .s_user    (s_user),
    .s_pixels  (s_pixels),
    .s_weights (s_weights),
    .s_ready   (s_ready),
    .m_valid   (e_valid),
    .m_last    (e_last),
    .m_user    (e_user),
    .m_pixels  (e_pixels),
    .m_weights (e_weights),
    .m_ready   (e_ready)
  );

  conv_engine engine (
    .clk       (clk),
    .rst       (rst),
    .s_valid   (e_valid),
    .s_last    (e_last),
    .s_user    (e_user),
    .s_pixels  (e_pixels),
    .s_weights (e_weights),
    .s_ready   (e_ready),
    .m_valid   (m_valid),
    .m_last    (m_last),
    .m_data    (m_data)
  );

endmodule

`default_nettype wire

//--- hdl/multiplier.sv
// Pipelined signed multiplier
`timescale 1ns/1ps
`default_nettype none
`include "conv_consts.svh"

module multiplier #(
  parameter int LATENCY = `CONV_LATENCY_MULTIPLIER
) (
  input  wire                clk,
  input  wire                ce,
  input  wire conv_pkg::pixel_t  a,
  input  wire conv_pkg::weight_t b,
  output conv_pkg::product_t     p
);

  conv_pkg::product_t pipe [LATENCY];

  always_ff @(posedge clk) begin
    if (ce) begin
      pipe[0] <= a * b;  // Both operands signed
      for (int i = 1; i < LATENCY; i++) begin
        pipe[i] <= pipe[i-1];
      end
    end
  end

  assign p = pipe[LATENCY-1];

endmodule

`default_nettype wire

//--- hdl/n_delay.sv
// Clock-enabled delay line
`timescale 1ns/1ps
`default_nettype none

module n_delay #(
  parameter int N     = 2,
  parameter int WIDTH = 1
) (
  input  wire              clk,
  input  wire              rst,
  input  wire              ce,
  input  wire  [WIDTH-1:0] data_in,
  output logic [WIDTH-1:0] data_out
);

  logic [WIDTH-1:0] stages [N];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < N; i++) begin
        stages[i] <= '0;
      end
    end else if (ce) begin
      stages[0] <= data_in;
      for (int i = 1; i < N; i++) begin
        stages[i] <= stages[i-1];
      end
    end
  end

  assign data_out = stages[N-1];

endmodule

`default_nettype wire

//--- include/conv_consts.svh
// Convolution engine constants
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// Lane counts
`define CONV_UNITS              4
`define CONV_MEMBERS            4

// Data widths
`define CONV_WORD_WIDTH         8
`define CONV_WORD_WIDTH_ACC     20

// Pipeline latencies
`define CONV_LATENCY_MULTIPLIER 2

// Kernel geometry
`define CONV_KW_MAX             3
`define CONV_BITS_KW2           1

// Side-band word layout
`define CONV_I_IS_W_FIRST       0
`define CONV_I_IS_CIN_LAST      1
`define CONV_I_KW2              2
`define CONV_USER_WIDTH         3

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the convolution engine testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
  -f conv_engine.f \
  --top-module conv_tb \
  -o Vconv_tb

# tee keeps the log even when the simulation stops on an error
./obj_dir/Vconv_tb 2>&1 | tee "$LOG"

if grep -q "test failed" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi

if ! grep -q "test passed" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi

echo "Simulation PASSED"

//--- tests/conv_tb.sv
// Convolution engine testbench
`timescale 1ns/1ps
`default_nettype none
`include "conv_consts.svh"

module conv_tb;

  localparam int UNITS       = `CONV_UNITS;
  localparam int MEMBERS     = `CONV_MEMBERS;
  localparam int MAX_BEATS   = 40;
  localparam int NUM_PACKETS = 13;
  localparam int TIMEOUT     = 40;
  localparam int DRIVE_DELAY = 10;

  // Beats, kw2, s_last, restart beat, fill (0 random, 1 max, 2 negative) and gaps
  localparam int PACKETS [NUM_PACKETS][6] = '{
    '{ 1, 0, 1, 0, 0, 0},  // Single beat
    '{ 1, 0, 0, 0, 2, 0},  // Negative product
    '{ 5, 0, 1, 0, 0, 0},
    '{40, 0, 0, 0, 1, 0},  // Wraps at 20 bits
    '{ 6, 0, 1, 3, 0, 0},  // First column mid-stream
    '{ 3, 1, 1, 0, 0, 0},  // k = 3
    '{ 1, 1, 0, 0, 2, 0},
    '{ 1, 1, 1, 0, 0, 0},  // Back to back stalls fill the skid
    '{ 2, 1, 0, 0, 0, 0},
    '{ 4, 1, 1, 0, 0, 1},  // Random valid gaps
    '{ 2, 0, 0, 0, 0, 1},
    '{ 3, 1, 1, 2, 0, 1},
    '{ 1, 0, 1, 0, 0, 0}
  };

  typedef conv_pkg::acc_t [MEMBERS-1:0][UNITS-1:0] result_t;

  logic                                  clk;
  logic                                  rst;
  logic                                  s_valid;
  logic                                  s_last;
  conv_pkg::user_t                       s_user;
  conv_pkg::pixel_t  [UNITS-1:0]         s_pixels;
  conv_pkg::weight_t [MEMBERS-1:0]       s_weights;
  logic                                  s_ready;
  logic                                  m_valid;
  logic                                  m_last;
  result_t                               m_data;

  conv_pkg::pixel_t  beat_pix [MAX_BEATS][UNITS];
  conv_pkg::weight_t beat_wts [MAX_BEATS][MEMBERS];
  result_t           exp_data_q [$];
  logic              exp_last_q [$];
  logic [31:0]       rng_state;

  conv_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .s_valid   (s_valid),
    .s_last    (s_last),
    .s_user    (s_user),
    .s_pixels  (s_pixels),
    .s_weights (s_weights),
    .s_ready   (s_ready),
    .m_valid   (m_valid),
    .m_last    (m_last),
    .m_data    (m_data)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic abort_test(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_acc(input string name, input conv_pkg::acc_t got,
                           input conv_pkg::acc_t exp);
    if (got !== exp) abort_test($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) abort_test($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_result(input result_t exp_data, input logic exp_last);
    for (int m = 0; m < MEMBERS; m++) begin
      for (int u = 0; u < UNITS; u++) begin
        check_acc($sformatf("m_data[%0d][%0d]", m, u), m_data[m][u], exp_data[m][u]);
      end
    end
    check_flag("m_last", m_last, exp_last);
  endtask

  task automatic make_beats(input int nbeats, input int fill);
    for (int b = 0; b < nbeats; b++) begin
      for (int u = 0; u < UNITS; u++) begin
        rng_state = xorshift32(rng_state);
        beat_pix[b][u] = (fill == 0) ? rng_state[7:0] : 8'h80;
      end
      for (int m = 0; m < MEMBERS; m++) begin
        rng_state = xorshift32(rng_state);
        case (fill)
          1:       beat_wts[b][m] = 8'h80;  // -128 * -128
          2:       beat_wts[b][m] = 8'h7f;  // -128 * 127
          default: beat_wts[b][m] = rng_state[7:0];
        endcase
      end
    end
  endtask

  // Reference sums over channels followed by the k-wide neighbor add
  function automatic result_t model_packet(input int nbeats, input int kw2, input int restart);
    result_t sums;
    result_t out;
    int      prod;
    int      k;
    sums = '0;
    k = 2 * kw2 + 1;
    for (int b = 0; b < nbeats; b++) begin
      for (int m = 0; m < MEMBERS; m++) begin
        for (int u = 0; u < UNITS; u++) begin
          prod = int'(beat_pix[b][u]) * int'(beat_wts[b][m]);
          if (b == 0 || b == restart) sums[m][u] = conv_pkg::acc_t'(prod);
          else sums[m][u] = sums[m][u] + conv_pkg::acc_t'(prod);
        end
      end
    end
    out = sums;
    if (kw2 != 0) begin
      for (int m = 1; m < MEMBERS; m++) begin
        for (int u = 0; u < UNITS; u++) begin
          if (m % k != 0) out[m][u] = sums[m][u] + sums[m-1][u];
        end
      end
    end
    return out;
  endfunction

  task automatic send_beat(input int b, input int nbeats, input int kw2, input logic last,
                           input int restart, input int gaps);
    conv_pkg::user_t user;
    int              idle;
    int              cnt;
    idle = 0;
    if (gaps != 0) begin
      rng_state = xorshift32(rng_state);
      idle = int'(rng_state % 3);
    end
    for (int i = 0; i < idle; i++) begin
      s_valid = 1'b0;
      @(posedge clk);
      #DRIVE_DELAY;
    end
    user = '0;
    user[`CONV_I_IS_W_FIRST]                 = (b == 0) || (b == restart);
    user[`CONV_I_IS_CIN_LAST]                = (b == nbeats - 1);
    user[`CONV_I_KW2 +: `CONV_BITS_KW2]      = conv_pkg::kw2_t'(kw2);
    s_valid = 1'b1;
    s_last  = (b == nbeats - 1) ? last : 1'b0;
    s_user  = user;
    for (int u = 0; u < UNITS; u++) s_pixels[u] = beat_pix[b][u];
    for (int m = 0; m < MEMBERS; m++) s_weights[m] = beat_wts[b][m];
    cnt = 0;
    while (!s_ready) begin  // Held while the skid entry is full
      cnt++;
      if (cnt > TIMEOUT) abort_test("Timed out waiting for s_ready to accept a beat");
      @(posedge clk);
      #DRIVE_DELAY;
    end
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  always @(negedge clk) begin
    if (!rst && m_valid) begin
      if (exp_data_q.size() == 0) begin
        abort_test("m_valid pulsed with no result expected");
      end else begin
        check_result(exp_data_q.pop_front(), exp_last_q.pop_front());
      end
    end
  end

  initial begin
    int      nbeats;
    int      cnt;
    logic    last;
    result_t expected;
    clk       = 1'b0;
    rst       = 1'b1;
    s_valid   = 1'b0;
    s_last    = 1'b0;
    s_user    = '0;
    s_pixels  = '0;
    s_weights = '0;
    rng_state = 32'h09e1fb7a;
    repeat (2) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;
    check_flag("s_ready", s_ready, 1'b1);
    check_flag("m_valid", m_valid, 1'b0);

    for (int p = 0; p < NUM_PACKETS; p++) begin
      nbeats = PACKETS[p][0];
      last   = PACKETS[p][2] != 0;
      make_beats(nbeats, PACKETS[p][4]);
      expected = model_packet(nbeats, PACKETS[p][1], PACKETS[p][3]);
      for (int b = 0; b < nbeats; b++) begin
        send_beat(b, nbeats, PACKETS[p][1], last, PACKETS[p][3], PACKETS[p][5]);
      end
      exp_data_q.push_back(expected);  // Output comes after the last beat is taken
      exp_last_q.push_back(last);
    end
    s_valid = 1'b0;

    cnt = 0;
    while (exp_data_q.size() != 0) begin
      cnt++;
      if (cnt > TIMEOUT) abort_test("Timed out waiting for m_valid on the remaining results");
      @(posedge clk);
    end
    repeat (10) @(posedge clk);  // Quiet period for stray strobes

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/conv_tb_asserts.sv
// Engine control assertions
`timescale 1ns/1ps
`default_nettype none

module conv_tb_asserts (
  input wire clk,
  input wire rst,
  input wire m_valid,
  input wire stall_sel,
  input wire s_ready
);

  // No output strobe while held in reset
  reset_quiet: assert property (@(posedge clk) rst && $past(rst) |-> !m_valid)
    else $error("m_valid high during reset");

  // Neighbor add takes exactly one cycle
  single_stall: assert property (@(posedge clk) disable iff (rst) stall_sel |=> !stall_sel)
    else $error("stall select high for two cycles in a row");

  stall_blocks_input: assert property (@(posedge clk) disable iff (rst) stall_sel |-> !s_ready)
    else $error("engine ready during a stall cycle");

endmodule

bind conv_engine conv_tb_asserts engine_checks (
  .clk       (clk),
  .rst       (rst),
  .m_valid   (m_valid),
  .stall_sel (stall_sel),
  .s_ready   (s_ready)
);

`default_nettype wire
